/* Makefile */
VERILATOR ?= verilator
TOP       ?= ctl_top_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+include
hw/ctl_pkg.sv
hw/settings_wr_if.sv
hw/ctl_sequencer.sv
hw/burst_counter.sv
hw/mod_settings_regs.sv
hw/silencer_settings_regs.sv
hw/ctl_top.sv
test/tb_clkgen.sv
test/ctl_props.sv
test/ctl_top_tb.sv

/* hw/burst_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_consts.svh"

module burst_counter (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    start,
    input  ctl_pkg::burst_op_t      op,
    input  logic [`CTL_DATA_W-1:0]  bus_dout,
    output logic                    rd_en,
    output logic [`CTL_ADDR_W-1:0]  rd_addr,
    output logic                    done,
    settings_wr_if.source           wr
);
    import ctl_pkg::*;

    localparam int LAT = `CTL_RD_LATENCY;

    logic                   active;
    burst_op_t              op_q;
    logic [`CTL_ADDR_W-1:0] base_q;
    logic [`CTL_IDX_W-1:0]  idx;
    logic [`CTL_IDX_W-1:0]  last_idx;
    logic [`CTL_ADDR_W-1:0] start_base;
    logic [`CTL_IDX_W-1:0]  start_last;
    logic [LAT-1:0]         pipe_vld;
    logic [LAT-1:0]         pipe_last;
    logic [`CTL_IDX_W-1:0]  pipe_idx [LAT];

    always_comb begin
        case (op)
            OP_RD_MOD: begin
                start_base = `CTL_ADDR_MOD_BASE;
                start_last = `CTL_IDX_W'(`CTL_MOD_WORDS - 1);
            end
            OP_RD_SIL: begin
                start_base = `CTL_ADDR_SIL_BASE;
                start_last = `CTL_IDX_W'(`CTL_SIL_WORDS - 1);
            end
            default: begin
                start_base = `CTL_ADDR_CTL_FLAG;
                start_last = '0;
            end
        endcase
    end

    assign rd_en = active;
    assign rd_addr = base_q + `CTL_ADDR_W'(idx);

    always_ff @(posedge CLK) begin
        if (rst) begin
            active <= 1'b0;
            pipe_vld <= '0;
        end else begin
            pipe_vld <= {pipe_vld[LAT-2:0], active};
            if (start && !active) begin
                active <= 1'b1;
            end else if (active && idx == last_idx) begin
                active <= 1'b0;
            end
        end
    end

    // Each issued index walks the pipeline alongside its memory read
    always_ff @(posedge CLK) begin
        pipe_idx[0] <= idx;
        pipe_last[0] <= (idx == last_idx);
        for (int s = 1; s < LAT; s++) begin
            pipe_idx[s] <= pipe_idx[s-1];
            pipe_last[s] <= pipe_last[s-1];
        end
        if (start && !active) begin
            op_q <= op;
            base_q <= start_base;
            last_idx <= start_last;
            idx <= '0;
        end else if (active) begin
            idx <= idx + 1'b1;
        end
    end

    assign wr.valid = pipe_vld[LAT-1];
    assign wr.op = op_q;
    assign wr.index = pipe_idx[LAT-1];
    assign wr.data = bus_dout;
    assign done = pipe_vld[LAT-1] && pipe_last[LAT-1];

endmodule

`default_nettype wire

/* hw/ctl_pkg.sv */
`default_nettype none

package ctl_pkg;

    typedef enum logic [2:0] {
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_POLL,
        ST_POLL_WAIT,
        ST_BURST,
        ST_WB_STATUS,
        ST_UPDATE
    } seq_state_t;

    typedef enum logic [1:0] {
        OP_RD_CTL,
        OP_RD_MOD,
        OP_RD_SIL
    } burst_op_t;

    typedef struct packed {
        logic        update;
        logic        req_rd_segment;
        logic [7:0]  transition_mode;
        logic [63:0] transition_value;
        logic [14:0] cycle0;
        logic [14:0] cycle1;
        logic [15:0] freq_div0;
        logic [15:0] freq_div1;
        logic [15:0] rep0;
        logic [15:0] rep1;
    } mod_settings_t;

    typedef struct packed {
        logic        update;
        logic [7:0]  flag;
        logic [15:0] update_rate_intensity;
        logic [15:0] update_rate_phase;
        logic [15:0] completion_steps_intensity;
        logic [15:0] completion_steps_phase;
    } silencer_settings_t;

endpackage

`default_nettype wire

/* hw/ctl_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_consts.svh"

module ctl_sequencer (
    input  logic                    CLK,
    input  logic                    rst,
    input  logic                    thermo,
    input  logic                    mod_segment,
    settings_wr_if.sink             wr,
    output logic                    burst_start,
    output ctl_pkg::burst_op_t      burst_op,
    input  logic                    burst_done,
    input  logic [`CTL_ADDR_W-1:0]  rd_addr,
    input  logic                    rd_en,
    output logic                    bus_we,
    output logic [`CTL_ADDR_W-1:0]  bus_addr,
    output logic [`CTL_DATA_W-1:0]  bus_din,
    output logic                    mod_update,
    output logic                    sil_update,
    output logic                    force_fan,
    output logic [3:0]              gpio_in
);
    import ctl_pkg::*;

    seq_state_t             state;
    logic                   we_q;
    logic [`CTL_ADDR_W-1:0] addr_q;
    logic [`CTL_DATA_W-1:0] din_q;
    logic [`CTL_DATA_W-1:0] ctl_flags;
    logic [`CTL_DATA_W-1:0] status_word;
    logic [`CTL_DATA_W-1:0] serviced_mask;
    logic                   flag_word_valid;

    assign status_word = {{(`CTL_DATA_W-2){1'b0}}, mod_segment, thermo};
    assign flag_word_valid = wr.valid && (wr.op == OP_RD_CTL);

    always_comb begin
        serviced_mask = '0;
        if (burst_op == OP_RD_MOD) begin
            serviced_mask[`CTL_FLAG_MOD_SET] = 1'b1;
        end else if (burst_op == OP_RD_SIL) begin
            serviced_mask[`CTL_FLAG_SIL_SET] = 1'b1;
        end
    end

    // The burst counter owns the address while its reads are in flight
    assign bus_we = we_q;
    assign bus_addr = rd_en ? rd_addr : addr_q;
    assign bus_din = din_q;

    assign force_fan = ctl_flags[`CTL_FLAG_FORCE_FAN];
    assign gpio_in = ctl_flags[`CTL_FLAG_GPIO_LSB +: 4];

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= ST_VER_MINOR;
            we_q <= 1'b0;
            burst_start <= 1'b0;
            burst_op <= OP_RD_CTL;
            ctl_flags <= '0;
            mod_update <= 1'b0;
            sil_update <= 1'b0;
        end else begin
            burst_start <= 1'b0;
            mod_update <= 1'b0;
            sil_update <= 1'b0;
            case (state)
                ST_VER_MINOR: begin
                    we_q <= 1'b1;
                    addr_q <= `CTL_ADDR_VERSION_MINOR;
                    din_q <= {{(`CTL_DATA_W-8){1'b0}}, `CTL_VERSION_MINOR};
                    state <= ST_VER_MAJOR;
                end
                ST_VER_MAJOR: begin
                    addr_q <= `CTL_ADDR_VERSION_MAJOR;
                    din_q <= {{(`CTL_DATA_W-8){1'b0}}, `CTL_VERSION_MAJOR};
                    state <= ST_POLL;
                end
                ST_POLL: begin
                    we_q <= 1'b0;
                    burst_start <= 1'b1; // One-word read of the flag register
                    burst_op <= OP_RD_CTL;
                    state <= ST_POLL_WAIT;
                end
                ST_POLL_WAIT: begin
                    if (flag_word_valid) begin
                        ctl_flags <= wr.data;
                        we_q <= 1'b1;
                        addr_q <= `CTL_ADDR_FPGA_STATE;
                        din_q <= status_word;
                        if (wr.data[`CTL_FLAG_MOD_SET]) begin
                            burst_start <= 1'b1; // Modulation wins over silencer
                            burst_op <= OP_RD_MOD;
                            state <= ST_BURST;
                        end else if (wr.data[`CTL_FLAG_SIL_SET]) begin
                            burst_start <= 1'b1;
                            burst_op <= OP_RD_SIL;
                            state <= ST_BURST;
                        end else begin
                            state <= ST_POLL;
                        end
                    end
                end
                ST_BURST: begin
                    we_q <= 1'b0;
                    if (burst_done) begin
                        we_q <= 1'b1;
                        addr_q <= `CTL_ADDR_CTL_FLAG;
                        din_q <= ctl_flags & ~serviced_mask;
                        ctl_flags <= ctl_flags & ~serviced_mask;
                        state <= ST_WB_STATUS;
                    end
                end
                ST_WB_STATUS: begin
                    addr_q <= `CTL_ADDR_FPGA_STATE;
                    din_q <= status_word;
                    state <= ST_UPDATE;
                end
                ST_UPDATE: begin
                    we_q <= 1'b0;
                    mod_update <= (burst_op == OP_RD_MOD);
                    sil_update <= (burst_op == OP_RD_SIL);
                    state <= ST_POLL;
                end
                default: begin
                    we_q <= 1'b0;
                    state <= ST_POLL;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hw/ctl_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_consts.svh"

module ctl_top (
    input  logic                   CLK,
    input  logic                   rst,
    input  logic                   thermo,
    input  logic                   mod_segment,
    output logic                   bus_we,
    output logic [`CTL_ADDR_W-1:0] bus_addr,
    output logic [`CTL_DATA_W-1:0] bus_din,
    input  logic [`CTL_DATA_W-1:0] bus_dout,
    output logic                   mod_update,
    output logic                   mod_req_rd_segment,
    output logic [7:0]             mod_transition_mode,
    output logic [63:0]            mod_transition_value,
    output logic [14:0]            mod_cycle0,
    output logic [14:0]            mod_cycle1,
    output logic [15:0]            mod_freq_div0,
    output logic [15:0]            mod_freq_div1,
    output logic [15:0]            mod_rep0,
    output logic [15:0]            mod_rep1,
    output logic                   sil_update,
    output logic [7:0]             sil_flag,
    output logic [15:0]            sil_update_rate_intensity,
    output logic [15:0]            sil_update_rate_phase,
    output logic [15:0]            sil_completion_steps_intensity,
    output logic [15:0]            sil_completion_steps_phase,
    output logic                   force_fan,
    output logic [3:0]             gpio_in
);
    import ctl_pkg::*;

    settings_wr_if wr ();

    logic                   burst_start;
    burst_op_t              burst_op;
    logic                   burst_done;
    logic                   rd_en;
    logic [`CTL_ADDR_W-1:0] rd_addr;
    logic                   mod_strobe;
    logic                   sil_strobe;
    mod_settings_t          mod_settings;
    silencer_settings_t     sil_settings;

    ctl_sequencer u_seq (
        .CLK         (CLK),
        .rst         (rst),
        .thermo      (thermo),
        .mod_segment (mod_segment),
        .wr          (wr.sink),
        .burst_start (burst_start),
        .burst_op    (burst_op),
        .burst_done  (burst_done),
        .rd_addr     (rd_addr),
        .rd_en       (rd_en),
        .bus_we      (bus_we),
        .bus_addr    (bus_addr),
        .bus_din     (bus_din),
        .mod_update  (mod_strobe),
        .sil_update  (sil_strobe),
        .force_fan   (force_fan),
        .gpio_in     (gpio_in)
    );

    burst_counter u_burst (
        .CLK      (CLK),
        .rst      (rst),
        .start    (burst_start),
        .op       (burst_op),
        .bus_dout (bus_dout),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .done     (burst_done),
        .wr       (wr.source)
    );

    mod_settings_regs u_mod (
        .CLK      (CLK),
        .rst      (rst),
        .wr       (wr.sink),
        .update   (mod_strobe),
        .settings (mod_settings)
    );

    silencer_settings_regs u_sil (
        .CLK      (CLK),
        .rst      (rst),
        .wr       (wr.sink),
        .update   (sil_strobe),
        .settings (sil_settings)
    );

    // Update outputs come from the records so fields and strobe line up
    assign mod_update = mod_settings.update;
    assign mod_req_rd_segment = mod_settings.req_rd_segment;
    assign mod_transition_mode = mod_settings.transition_mode;
    assign mod_transition_value = mod_settings.transition_value;
    assign mod_cycle0 = mod_settings.cycle0;
    assign mod_cycle1 = mod_settings.cycle1;
    assign mod_freq_div0 = mod_settings.freq_div0;
    assign mod_freq_div1 = mod_settings.freq_div1;
    assign mod_rep0 = mod_settings.rep0;
    assign mod_rep1 = mod_settings.rep1;

    assign sil_update = sil_settings.update;
    assign sil_flag = sil_settings.flag;
    assign sil_update_rate_intensity = sil_settings.update_rate_intensity;
    assign sil_update_rate_phase = sil_settings.update_rate_phase;
    assign sil_completion_steps_intensity = sil_settings.completion_steps_intensity;
    assign sil_completion_steps_phase = sil_settings.completion_steps_phase;

endmodule

`default_nettype wire

/* hw/mod_settings_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_settings_regs (
    input  logic                  CLK,
    input  logic                  rst,
    settings_wr_if.sink           wr,
    input  logic                  update,
    output ctl_pkg::mod_settings_t settings
);
    import ctl_pkg::*;

    always_ff @(posedge CLK) begin
        if (rst) begin
            settings.update <= 1'b0;
            settings.req_rd_segment <= 1'b0;
            settings.transition_mode <= 8'd0;
            settings.transition_value <= 64'd0;
            settings.cycle0 <= 15'd1;
            settings.cycle1 <= 15'd1;
            settings.freq_div0 <= 16'd10;
            settings.freq_div1 <= 16'd10;
            settings.rep0 <= 16'hFFFF;
            settings.rep1 <= 16'hFFFF;
        end else begin
            settings.update <= update; // Lands after the last field is in
            if (wr.valid && wr.op == OP_RD_MOD) begin
                case (wr.index)
                    4'd0: settings.req_rd_segment <= wr.data[0];
                    4'd1: settings.transition_mode <= wr.data[7:0];
                    4'd2: settings.transition_value[15:0] <= wr.data;
                    4'd3: settings.transition_value[31:16] <= wr.data;
                    4'd4: settings.transition_value[47:32] <= wr.data;
                    4'd5: settings.transition_value[63:48] <= wr.data;
                    4'd6: settings.cycle0 <= wr.data[14:0];
                    4'd7: settings.cycle1 <= wr.data[14:0];
                    4'd8: settings.freq_div0 <= wr.data;
                    4'd9: settings.freq_div1 <= wr.data;
                    4'd10: settings.rep0 <= wr.data;
                    4'd11: settings.rep1 <= wr.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/settings_wr_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_consts.svh"

// Words returned by a burst read, tagged with their opcode and position
interface settings_wr_if;
    import ctl_pkg::*;

    logic                  valid;
    burst_op_t             op;
    logic [`CTL_IDX_W-1:0] index;
    logic [`CTL_DATA_W-1:0] data;

    modport source (output valid, op, index, data);
    modport sink (input valid, op, index, data);

endinterface

`default_nettype wire

/* hw/silencer_settings_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module silencer_settings_regs (
    input  logic                       CLK,
    input  logic                       rst,
    settings_wr_if.sink                wr,
    input  logic                       update,
    output ctl_pkg::silencer_settings_t settings
);
    import ctl_pkg::*;

    always_ff @(posedge CLK) begin
        if (rst) begin
            settings.update <= 1'b0;
            settings.flag <= 8'd0;
            settings.update_rate_intensity <= 16'd256;
            settings.update_rate_phase <= 16'd256;
            settings.completion_steps_intensity <= 16'd10;
            settings.completion_steps_phase <= 16'd40;
        end else begin
            settings.update <= update;
            if (wr.valid && wr.op == OP_RD_SIL) begin
                case (wr.index)
                    4'd0: settings.flag <= wr.data[7:0];
                    4'd1: settings.update_rate_intensity <= wr.data;
                    4'd2: settings.update_rate_phase <= wr.data;
                    4'd3: settings.completion_steps_intensity <= wr.data;
                    4'd4: settings.completion_steps_phase <= wr.data;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* include/ctl_consts.svh */
`ifndef CTL_CONSTS_SVH
`define CTL_CONSTS_SVH

// Control bus geometry
`define CTL_ADDR_W 8
`define CTL_DATA_W 16
`define CTL_RD_LATENCY 2

// Word index inside a burst
`define CTL_IDX_W 4

// Control register map
`define CTL_ADDR_CTL_FLAG 8'h00
`define CTL_ADDR_FPGA_STATE 8'h01
`define CTL_ADDR_VERSION_MAJOR 8'h02
`define CTL_ADDR_VERSION_MINOR 8'h03

// Settings blocks, words are contiguous from the base
`define CTL_ADDR_MOD_BASE 8'h20
`define CTL_ADDR_SIL_BASE 8'h60
`define CTL_MOD_WORDS 12
`define CTL_SIL_WORDS 5

// Bit positions in the control flag word
`define CTL_FLAG_MOD_SET 0
`define CTL_FLAG_SIL_SET 2
`define CTL_FLAG_FORCE_FAN 4
`define CTL_FLAG_GPIO_LSB 8

// Firmware version reported at startup
`define CTL_VERSION_MAJOR 8'hA2
`define CTL_VERSION_MINOR 8'h01

`endif

/* test/ctl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module ctl_props (
    input logic CLK,
    input logic rst,
    input logic bus_we,
    input logic mod_update,
    input logic sil_update
);
    mod_update_single: assert property (@(posedge CLK) disable iff (rst)
        mod_update |=> !mod_update)
        else $error("mod_update stayed high for more than one cycle");

    sil_update_single: assert property (@(posedge CLK) disable iff (rst)
        sil_update |=> !sil_update)
        else $error("sil_update stayed high for more than one cycle");

    updates_exclusive: assert property (@(posedge CLK) disable iff (rst)
        !(mod_update && sil_update))
        else $error("mod_update and sil_update high together");

    we_low_in_reset: assert property (@(posedge CLK) rst |=> !bus_we)
        else $error("bus_we high while reset is applied");
endmodule

bind ctl_top ctl_props u_props (
    .CLK        (CLK),
    .rst        (rst),
    .bus_we     (bus_we),
    .mod_update (mod_update),
    .sil_update (sil_update)
);

`default_nettype wire

/* test/ctl_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "ctl_consts.svh"

module ctl_top_tb;
    localparam int WAIT_LIMIT = 400;
    localparam int MEM_WORDS = 1 << `CTL_ADDR_W;

    logic                   CLK;
    logic                   rst;
    logic                   thermo;
    logic                   mod_segment;
    logic                   bus_we;
    logic [`CTL_ADDR_W-1:0] bus_addr;
    logic [`CTL_DATA_W-1:0] bus_din;
    logic [`CTL_DATA_W-1:0] bus_dout = '0;
    logic                   mod_update;
    logic                   mod_req_rd_segment;
    logic [7:0]             mod_transition_mode;
    logic [63:0]            mod_transition_value;
    logic [14:0]            mod_cycle0;
    logic [14:0]            mod_cycle1;
    logic [15:0]            mod_freq_div0;
    logic [15:0]            mod_freq_div1;
    logic [15:0]            mod_rep0;
    logic [15:0]            mod_rep1;
    logic                   sil_update;
    logic [7:0]             sil_flag;
    logic [15:0]            sil_update_rate_intensity;
    logic [15:0]            sil_update_rate_phase;
    logic [15:0]            sil_completion_steps_intensity;
    logic [15:0]            sil_completion_steps_phase;
    logic                   force_fan;
    logic [3:0]             gpio_in;

    logic [`CTL_DATA_W-1:0] mem [MEM_WORDS];
    logic [`CTL_ADDR_W-1:0] rd_addr_q [`CTL_RD_LATENCY];
    logic [`CTL_ADDR_W-1:0] wr_log_addr [$];
    logic [`CTL_DATA_W-1:0] wr_log_data [$];
    logic                   host_we;
    logic [`CTL_ADDR_W-1:0] host_addr;
    logic [`CTL_DATA_W-1:0] host_data;
    logic [`CTL_DATA_W-1:0] mod_words [`CTL_MOD_WORDS];
    logic [`CTL_DATA_W-1:0] sil_words [`CTL_SIL_WORDS];
    int                     errors;
    int                     checks;

    tb_clkgen u_clk (.CLK(CLK));

    ctl_top DUT (.*);

    // Memory model with a fixed read latency, DUT writes win over host writes
    always @(posedge CLK) begin
        if (rst) begin
            for (int a = 0; a < MEM_WORDS; a++) begin
                mem[a] <= {8'(a) ^ 8'h5A, 8'(a)};
            end
            mem[`CTL_ADDR_CTL_FLAG] <= '0; // No set bits pending at startup
        end else begin
            if (host_we) begin
                mem[host_addr] <= host_data;
            end
            if (bus_we) begin
                mem[bus_addr] <= bus_din;
                wr_log_addr.push_back(bus_addr);
                wr_log_data.push_back(bus_din);
            end
        end
        rd_addr_q[0] <= bus_addr;
        for (int s = 1; s < `CTL_RD_LATENCY; s++) begin
            rd_addr_q[s] <= rd_addr_q[s-1];
        end
    end

    always @(negedge CLK) begin
        bus_dout <= mem[rd_addr_q[`CTL_RD_LATENCY-1]];
    end

    task automatic expect_equal(input string name, input logic [63:0] got,
                                input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic write_mem_word(input logic [`CTL_ADDR_W-1:0] addr,
                                  input logic [`CTL_DATA_W-1:0] data);
        host_addr = addr;
        host_data = data;
        host_we = 1'b1;
        @(negedge CLK);
        host_we = 1'b0;
    endtask

    task automatic load_random_words(input bit to_mod);
        int                     count;
        logic [`CTL_ADDR_W-1:0] base;
        logic [`CTL_DATA_W-1:0] w;
        count = to_mod ? `CTL_MOD_WORDS : `CTL_SIL_WORDS;
        base = to_mod ? `CTL_ADDR_MOD_BASE : `CTL_ADDR_SIL_BASE;
        for (int i = 0; i < count; i++) begin
            w = 16'($urandom());
            if (to_mod) begin
                mod_words[i] = w;
            end else begin
                sil_words[i] = w;
            end
            write_mem_word(base + 8'(i), w);
        end
    endtask

    task automatic wait_for_update(input bit on_mod, output bit seen);
        seen = 1'b0;
        for (int cyc = 0; cyc < WAIT_LIMIT && !seen; cyc++) begin
            @(negedge CLK);
            seen = on_mod ? mod_update : sil_update;
        end
        if (!seen) begin
            errors++;
            $display("Error: timed out waiting for %s", on_mod ? "mod_update" : "sil_update");
        end
    endtask

    task automatic compare_mod_outputs();
        expect_equal("mod_req_rd_segment", mod_req_rd_segment, mod_words[0][0]);
        expect_equal("mod_transition_mode", mod_transition_mode, mod_words[1][7:0]);
        expect_equal("mod_transition_value", mod_transition_value,
                     {mod_words[5], mod_words[4], mod_words[3], mod_words[2]});
        expect_equal("mod_cycle0", mod_cycle0, mod_words[6][14:0]);
        expect_equal("mod_cycle1", mod_cycle1, mod_words[7][14:0]);
        expect_equal("mod_freq_div0", mod_freq_div0, mod_words[8]);
        expect_equal("mod_freq_div1", mod_freq_div1, mod_words[9]);
        expect_equal("mod_rep0", mod_rep0, mod_words[10]);
        expect_equal("mod_rep1", mod_rep1, mod_words[11]);
    endtask

    task automatic compare_sil_outputs();
        expect_equal("sil_flag", sil_flag, sil_words[0][7:0]);
        expect_equal("sil_update_rate_intensity", sil_update_rate_intensity, sil_words[1]);
        expect_equal("sil_update_rate_phase", sil_update_rate_phase, sil_words[2]);
        expect_equal("sil_completion_steps_intensity", sil_completion_steps_intensity,
                     sil_words[3]);
        expect_equal("sil_completion_steps_phase", sil_completion_steps_phase, sil_words[4]);
    endtask

    task automatic check_reset_and_version();
        int cyc;
        expect_equal("bus_we", bus_we, 1'b0);
        expect_equal("mod_update", mod_update, 1'b0);
        expect_equal("mod_req_rd_segment", mod_req_rd_segment, 1'b0);
        expect_equal("mod_transition_mode", mod_transition_mode, 8'd0);
        expect_equal("mod_transition_value", mod_transition_value, 64'd0);
        expect_equal("mod_cycle0", mod_cycle0, 15'd1);
        expect_equal("mod_cycle1", mod_cycle1, 15'd1);
        expect_equal("mod_freq_div0", mod_freq_div0, 16'd10);
        expect_equal("mod_freq_div1", mod_freq_div1, 16'd10);
        expect_equal("mod_rep0", mod_rep0, 16'hFFFF);
        expect_equal("mod_rep1", mod_rep1, 16'hFFFF);
        expect_equal("sil_update", sil_update, 1'b0);
        expect_equal("sil_flag", sil_flag, 8'd0);
        expect_equal("sil_update_rate_intensity", sil_update_rate_intensity, 16'd256);
        expect_equal("sil_update_rate_phase", sil_update_rate_phase, 16'd256);
        expect_equal("sil_completion_steps_intensity", sil_completion_steps_intensity, 16'd10);
        expect_equal("sil_completion_steps_phase", sil_completion_steps_phase, 16'd40);
        expect_equal("force_fan", force_fan, 1'b0);
        expect_equal("gpio_in", gpio_in, 4'd0);
        cyc = 0;
        while (cyc < WAIT_LIMIT && wr_log_addr.size() < 2) begin
            @(negedge CLK);
            cyc++;
        end
        if (wr_log_addr.size() < 2) begin
            errors++;
            $display("Error: the two version writes never appeared on the bus");
        end else begin
            expect_equal("first write bus_addr", wr_log_addr[0], `CTL_ADDR_VERSION_MINOR);
            expect_equal("first write bus_din", wr_log_data[0], {8'h00, `CTL_VERSION_MINOR});
            expect_equal("second write bus_addr", wr_log_addr[1], `CTL_ADDR_VERSION_MAJOR);
            expect_equal("second write bus_din", wr_log_data[1], {8'h00, `CTL_VERSION_MAJOR});
        end
    endtask

    task automatic load_modulation_block();
        bit seen;
        load_random_words(1'b1);
        write_mem_word(`CTL_ADDR_CTL_FLAG, 16'd1 << `CTL_FLAG_MOD_SET);
        wait_for_update(1'b1, seen);
        if (seen) begin
            compare_mod_outputs();
            expect_equal("flag word MOD_SET", mem[`CTL_ADDR_CTL_FLAG][`CTL_FLAG_MOD_SET], 1'b0);
        end
    endtask

    task automatic load_silencer_block();
        bit seen;
        load_random_words(1'b0);
        write_mem_word(`CTL_ADDR_CTL_FLAG, 16'd1 << `CTL_FLAG_SIL_SET);
        wait_for_update(1'b0, seen);
        if (seen) begin
            compare_sil_outputs();
            expect_equal("flag word SIL_SET", mem[`CTL_ADDR_CTL_FLAG][`CTL_FLAG_SIL_SET], 1'b0);
        end
    endtask

    task automatic check_block_priority();
        int cyc;
        bit seen;
        load_random_words(1'b1);
        load_random_words(1'b0);
        write_mem_word(`CTL_ADDR_CTL_FLAG,
                       (16'd1 << `CTL_FLAG_MOD_SET) | (16'd1 << `CTL_FLAG_SIL_SET));
        cyc = 0;
        while (cyc < WAIT_LIMIT && !mod_update && !sil_update) begin
            @(negedge CLK);
            cyc++;
        end
        if (!mod_update && !sil_update) begin
            errors++;
            $display("Error: timed out waiting for an update strobe with both set bits raised");
        end else if (sil_update) begin
            errors++;
            $display("Error: sil_update pulsed before mod_update with both set bits raised");
        end else begin
            compare_mod_outputs();
            wait_for_update(1'b0, seen);
            if (seen) begin
                compare_sil_outputs();
                expect_equal("flag word", mem[`CTL_ADDR_CTL_FLAG], 16'd0);
            end
        end
    endtask

    task automatic follow_status_and_flags();
        logic                   exp_thermo;
        logic                   exp_seg;
        logic                   exp_fan;
        logic [3:0]             exp_gpio;
        int                     pos;
        int                     cyc;
        bit                     found;
        for (int round = 0; round < 4; round++) begin
            exp_thermo = 1'($urandom());
            exp_seg = 1'($urandom());
            thermo = exp_thermo;
            mod_segment = exp_seg;
            pos = wr_log_addr.size();
            found = 1'b0;
            for (cyc = 0; cyc < WAIT_LIMIT && !found; cyc++) begin
                @(negedge CLK);
                while (pos < wr_log_addr.size() && !found) begin
                    if (wr_log_addr[pos] == `CTL_ADDR_FPGA_STATE &&
                        wr_log_data[pos][1:0] == {exp_seg, exp_thermo}) begin
                        found = 1'b1;
                    end else begin
                        pos++;
                    end
                end
            end
            if (!found) begin
                errors++;
                $display("Error: no status write followed thermo=%0b mod_segment=%0b",
                         exp_thermo, exp_seg);
            end else begin
                expect_equal("status word bus_din", wr_log_data[pos],
                             {14'd0, exp_seg, exp_thermo});
            end
        end
        for (int round = 0; round < 3; round++) begin
            exp_fan = ~round[0]; // Fan bit toggles every round so force_fan has to move
            exp_gpio = 4'($urandom());
            write_mem_word(`CTL_ADDR_CTL_FLAG, (16'(exp_fan) << `CTL_FLAG_FORCE_FAN) |
                                               (16'(exp_gpio) << `CTL_FLAG_GPIO_LSB));
            cyc = 0;
            while (cyc < WAIT_LIMIT && (force_fan !== exp_fan || gpio_in !== exp_gpio)) begin
                @(negedge CLK);
                cyc++;
            end
            checks++;
            if (force_fan !== exp_fan || gpio_in !== exp_gpio) begin
                errors++;
                $display("Error: force_fan and gpio_in did not follow the flag word");
            end
        end
    endtask

    initial begin
        void'($urandom(32'h5435_32c4));
        errors = 0;
        checks = 0;
        rst = 1'b1;
        thermo = 1'b0;
        mod_segment = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_data = '0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        rst = 1'b0;
        check_reset_and_version();
        load_modulation_block();
        load_silencer_block();
        check_block_priority();
        follow_status_and_flags();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* test/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic CLK
);
    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2.0) CLK = ~CLK;
    end
endmodule

`default_nettype wire
